//--- common/mem_geom_pkg.sv
package mem_geom_pkg;

  // default geometry, the top level hands these down as parameters
  parameter int DEF_WIDTH   = 16;
  parameter int DEF_NUMVBNK = 4;
  parameter int DEF_NUMVROW = 16;

  // logical bank lives in the low address bits
  function automatic logic [31:0] bank_of(input logic [31:0] adr, input int unsigned bitvbnk);
    logic [31:0] mask;
    mask = (32'd1 << bitvbnk) - 32'd1;
    return adr & mask;
  endfunction

  // row is whatever sits above the bank field
  function automatic logic [31:0] row_of(input logic [31:0] adr, input int unsigned bitvbnk);
    return adr >> bitvbnk;
  endfunction

endpackage

//--- common/remap_pkg.sv
package remap_pkg;

  // one spare physical bank on top of the logical ones
  parameter int NUMSPARE = 1;

  // cycles from bank read enable to data on the bank output
  parameter int BANK_DELAY = 1;

endpackage

//--- design/remap/remap_table.sv
module remap_table #(
  parameter int WIDTH   = mem_geom_pkg::DEF_WIDTH,
  parameter int NUMVBNK = mem_geom_pkg::DEF_NUMVBNK,
  parameter int NUMVROW = mem_geom_pkg::DEF_NUMVROW,
  parameter int BITADDR = $clog2(NUMVBNK * NUMVROW),
  localparam int NUMPBNK = NUMVBNK + remap_pkg::NUMSPARE,
  localparam int BITPBNK = $clog2(NUMPBNK),
  localparam int BITVROW = $clog2(NUMVROW)
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       read,
  input  logic [BITADDR-1:0]         rd_adr,
  input  logic                       write,
  input  logic [BITADDR-1:0]         wr_adr,
  input  logic [WIDTH-1:0]           din,
  output logic [NUMPBNK-1:0]         bank_en,
  output logic [NUMPBNK-1:0]         bank_we,
  output logic [NUMPBNK*BITVROW-1:0] bank_row,
  output logic [WIDTH-1:0]           wr_data,
  output logic [BITPBNK-1:0]         rd_pbank,
  output logic                       rd_take
);

  import mem_geom_pkg::*;

  localparam int BITVBNK = $clog2(NUMVBNK);

  // per row: where each logical bank sits, and which physical bank is unused
  logic [BITPBNK-1:0] map_q  [NUMVROW][NUMVBNK];
  logic [BITPBNK-1:0] free_q [NUMVROW];

  logic [BITVROW-1:0] rd_row;
  logic [BITVBNK-1:0] rd_bank;
  logic [BITVROW-1:0] wr_row;
  logic [BITVBNK-1:0] wr_bank;

  logic [BITPBNK-1:0] wr_home;
  logic [BITPBNK-1:0] wr_pbank;
  logic               conflict;

  assign rd_row  = BITVROW'(row_of(32'(rd_adr), BITVBNK));
  assign rd_bank = BITVBNK'(bank_of(32'(rd_adr), BITVBNK));
  assign wr_row  = BITVROW'(row_of(32'(wr_adr), BITVBNK));
  assign wr_bank = BITVBNK'(bank_of(32'(wr_adr), BITVBNK));

  // lookups use the map as it stands before this edge
  assign rd_pbank = map_q[rd_row][rd_bank];
  assign wr_home  = map_q[wr_row][wr_bank];

  // same physical bank for both ports, push the write to the free bank
  assign conflict = read && write && (rd_pbank == wr_home);
  assign wr_pbank = conflict ? free_q[wr_row] : wr_home;

  assign wr_data = din;
  assign rd_take = read;

  always_comb begin
    logic rd_hit;
    logic wr_hit;
    bank_en  = '0;
    bank_we  = '0;
    bank_row = '0;
    for (int p = 0; p < NUMPBNK; p++) begin
      rd_hit = read && (rd_pbank == BITPBNK'(p));
      wr_hit = write && (wr_pbank == BITPBNK'(p));
      bank_en[p] = rd_hit || wr_hit;
      bank_we[p] = wr_hit;
      // the two ports never land on one bank, so this choice is unambiguous
      bank_row[p*BITVROW +: BITVROW] = wr_hit ? wr_row : rd_row;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < NUMVROW; r++) begin
        for (int b = 0; b < NUMVBNK; b++) begin
          map_q[r][b] <= BITPBNK'(b);
        end
        free_q[r] <= BITPBNK'(NUMVBNK);
      end
    end else if (conflict) begin
      // steered word takes the free bank, its old home becomes free
      map_q[wr_row][wr_bank] <= free_q[wr_row];
      free_q[wr_row]         <= wr_home;
    end
  end

endmodule

//--- design/sram_bank.sv
module sram_bank #(
  parameter int WIDTH   = mem_geom_pkg::DEF_WIDTH,
  parameter int NUMVROW = mem_geom_pkg::DEF_NUMVROW,
  localparam int BITVROW = $clog2(NUMVROW)
) (
  input  logic               clk,
  input  logic               en,
  input  logic               we,
  input  logic [BITVROW-1:0] row,
  input  logic [WIDTH-1:0]   wdata,
  output logic [WIDTH-1:0]   rdata
);

  logic [WIDTH-1:0] mem [NUMVROW];

  // single port, either a write or a read in a cycle
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[row] <= wdata;
      end else begin
        rdata <= mem[row];
      end
    end
  end

endmodule

//--- design/read_select.sv
module read_select #(
  parameter int WIDTH   = mem_geom_pkg::DEF_WIDTH,
  parameter int NUMVBNK = mem_geom_pkg::DEF_NUMVBNK,
  localparam int NUMPBNK = NUMVBNK + remap_pkg::NUMSPARE,
  localparam int BITPBNK = $clog2(NUMPBNK)
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     rd_take,
  input  logic [BITPBNK-1:0]       rd_pbank,
  input  logic [NUMPBNK*WIDTH-1:0] bank_dout,
  output logic                     rd_vld,
  output logic [WIDTH-1:0]         rd_dout
);

  import remap_pkg::*;

  // delay line matching the bank read latency
  logic [BANK_DELAY-1:0] take_pipe;
  logic [BITPBNK-1:0]    pbank_pipe [BANK_DELAY];

  always_ff @(posedge clk) begin
    if (rst) begin
      take_pipe <= '0;
    end else begin
      take_pipe[0] <= rd_take;
      for (int i = 1; i < BANK_DELAY; i++) begin
        take_pipe[i] <= take_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    pbank_pipe[0] <= rd_pbank;
    for (int i = 1; i < BANK_DELAY; i++) begin
      pbank_pipe[i] <= pbank_pipe[i-1];
    end
  end

  assign rd_vld  = take_pipe[BANK_DELAY-1];
  assign rd_dout = bank_dout[pbank_pipe[BANK_DELAY-1]*WIDTH +: WIDTH];

endmodule

//--- design/remap_mem_top.sv
module remap_mem_top #(
  parameter int WIDTH   = mem_geom_pkg::DEF_WIDTH,
  parameter int NUMVBNK = mem_geom_pkg::DEF_NUMVBNK,
  parameter int NUMVROW = mem_geom_pkg::DEF_NUMVROW,
  parameter int BITADDR = $clog2(mem_geom_pkg::DEF_NUMVBNK * mem_geom_pkg::DEF_NUMVROW)
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               write,
  input  logic [BITADDR-1:0] wr_adr,
  input  logic [WIDTH-1:0]   din,
  input  logic               read,
  input  logic [BITADDR-1:0] rd_adr,
  output logic               rd_vld,
  output logic [WIDTH-1:0]   rd_dout
);

  import remap_pkg::*;

  localparam int NUMPBNK = NUMVBNK + NUMSPARE;
  localparam int BITPBNK = $clog2(NUMPBNK);
  localparam int BITVROW = $clog2(NUMVROW);

  logic [NUMPBNK-1:0]         bank_en;
  logic [NUMPBNK-1:0]         bank_we;
  logic [NUMPBNK*BITVROW-1:0] bank_row;
  logic [WIDTH-1:0]           wr_data;
  logic [NUMPBNK*WIDTH-1:0]   bank_dout;
  logic [BITPBNK-1:0]         rd_pbank;
  logic                       rd_take;

  remap_table #(
    .WIDTH   (WIDTH),
    .NUMVBNK (NUMVBNK),
    .NUMVROW (NUMVROW),
    .BITADDR (BITADDR)
  ) u_remap_table (
    .clk      (clk),
    .rst      (rst),
    .read     (read),
    .rd_adr   (rd_adr),
    .write    (write),
    .wr_adr   (wr_adr),
    .din      (din),
    .bank_en  (bank_en),
    .bank_we  (bank_we),
    .bank_row (bank_row),
    .wr_data  (wr_data),
    .rd_pbank (rd_pbank),
    .rd_take  (rd_take)
  );

  // logical banks plus the spare, all alike
  for (genvar p = 0; p < NUMPBNK; p++) begin : g_bank
    sram_bank #(
      .WIDTH   (WIDTH),
      .NUMVROW (NUMVROW)
    ) u_bank (
      .clk   (clk),
      .en    (bank_en[p]),
      .we    (bank_we[p]),
      .row   (bank_row[p*BITVROW +: BITVROW]),
      .wdata (wr_data),
      .rdata (bank_dout[p*WIDTH +: WIDTH])
    );
  end

  read_select #(
    .WIDTH   (WIDTH),
    .NUMVBNK (NUMVBNK)
  ) u_read_select (
    .clk       (clk),
    .rst       (rst),
    .rd_take   (rd_take),
    .rd_pbank  (rd_pbank),
    .bank_dout (bank_dout),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout)
  );

endmodule

//--- verif/clk_gen.sv
module clk_gen #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset released a little after an edge, like the other inputs
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #10 rst = 1'b0;
  end

endmodule

//--- verif/remap_mem_chk.sv
module remap_table_chk #(
  parameter int NUMPBNK = 5,
  parameter int BITPBNK = 3
) (
  input logic               clk,
  input logic               rst,
  input logic               read,
  input logic               write,
  input logic [NUMPBNK-1:0] bank_en,
  input logic [NUMPBNK-1:0] bank_we,
  input logic [BITPBNK-1:0] rd_pbank,
  input logic [BITPBNK-1:0] rd_free
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;

  // a write lands on exactly one physical bank, and that bank is enabled
  a_we_has_en: assert property (@(posedge clk) disable iff (rst)
    ((bank_we & ~bank_en) == '0) && ($countones(bank_we) == (write ? 1 : 0)))
    else begin
      $error("bank write enable without bank enable, or not exactly one bank written");
      fail_cnt++;
    end

  // the read bank must never be the one taking the write
  a_read_not_written: assert property (@(posedge clk) disable iff (rst)
    (read && write) |-> !bank_we[rd_pbank])
    else begin
      $error("read and write share a physical bank");
      fail_cnt++;
    end

  a_read_not_free: assert property (@(posedge clk) disable iff (rst)
    read |-> (rd_pbank != rd_free))
    else begin
      $error("read uses the free bank of its row");
      fail_cnt++;
    end

endmodule

bind remap_table remap_table_chk #(
  .NUMPBNK (NUMPBNK),
  .BITPBNK (BITPBNK)
) u_chk (
  .clk      (clk),
  .rst      (rst),
  .read     (read),
  .write    (write),
  .bank_en  (bank_en),
  .bank_we  (bank_we),
  .rd_pbank (rd_pbank),
  .rd_free  (free_q[rd_row])
);

//--- verif/remap_mem_tb.sv
module remap_mem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import mem_geom_pkg::*;
  import remap_pkg::*;

  localparam int WIDTH     = DEF_WIDTH;
  localparam int NUMADR    = DEF_NUMVBNK * DEF_NUMVROW;
  localparam int BITADDR   = $clog2(NUMADR);
  localparam int BITVBNK   = $clog2(DEF_NUMVBNK);
  localparam int PERIOD    = 100;
  localparam int DRIVE_DLY = 10;
  localparam int N_STEER   = 48;
  localparam int N_SAME    = 16;
  localparam int N_TIMING  = 40;
  localparam int N_RANDOM  = 2000;
  // upper bounds on the cycles each phase takes
  localparam int TOTAL_CYCLES = 10 + (2 * NUMADR + 2) + (2 * N_STEER + 2) + (2 * N_SAME + 2)
                                + (4 * N_TIMING + 2) + (N_RANDOM + 2);

  logic               clk;
  logic               rst;
  logic               write;
  logic [BITADDR-1:0] wr_adr;
  logic [WIDTH-1:0]   din;
  logic               read;
  logic [BITADDR-1:0] rd_adr;
  logic               rd_vld;
  logic [WIDTH-1:0]   rd_dout;

  logic [WIDTH-1:0] model [int unsigned];
  logic             exp_rd_q [$];
  int unsigned      exp_adr_q [$];
  logic [WIDTH-1:0] exp_val_q [$];
  logic             exp_known_q [$];
  int unsigned      checks = 0;
  int unsigned      errors = 0;

  clk_gen #(.PERIOD(PERIOD), .RST_CYCLES(8)) u_clk_gen (.clk(clk), .rst(rst));

  remap_mem_top UUT (
    .clk     (clk),
    .rst     (rst),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  function automatic int unsigned make_adr(input int unsigned row, input int unsigned bank);
    return (row << BITVBNK) | bank;
  endfunction

  // outputs here answer the cycle driven BANK_DELAY cycles earlier
  task automatic check_response();
    int unsigned      a;
    logic [WIDTH-1:0] v;
    logic             k;
    logic             due;
    checks++;
    due = 1'b0;
    if (exp_rd_q.size() >= BANK_DELAY) begin
      due = exp_rd_q.pop_front();
    end
    if (due) begin
      a = exp_adr_q.pop_front();
      v = exp_val_q.pop_front();
      k = exp_known_q.pop_front();
      assert (rd_vld === 1'b1) else begin
        $display("rd_vld did not rise in the cycle after the read of address %0d", a);
        errors++;
      end
      if (rd_vld === 1'b1 && k) begin
        checks++;
        assert (rd_dout === v) else begin
          $display("FAILED at %0t: address %0d read %h, expected %h", $time, a, rd_dout, v);
          errors++;
        end
      end
    end else begin
      assert (rd_vld === 1'b0) else begin
        $display("FAILED at %0t: rd_vld high with no read in the previous cycle", $time);
        errors++;
      end
    end
  endtask

  task automatic drive_cycle(input logic rd, input int unsigned ra, input logic wr,
                             input int unsigned wa, input logic [WIDTH-1:0] wd);
    @(posedge clk);
    #(DRIVE_DLY);
    check_response();
    read   = rd;
    rd_adr = BITADDR'(ra);
    write  = wr;
    wr_adr = BITADDR'(wa);
    din    = wd;
    exp_rd_q.push_back(rd);
    // the read sees the contents before this cycle's write
    if (rd) begin
      exp_adr_q.push_back(ra);
      exp_known_q.push_back(model.exists(ra));
      exp_val_q.push_back(model.exists(ra) ? model[ra] : '0);
    end
    if (wr) begin
      model[wa] = wd;
    end
  endtask

  task automatic idle();
    drive_cycle(1'b0, 0, 1'b0, 0, '0);
  endtask

  task automatic end_test(input int num, input string name, input int unsigned c0,
                          input int unsigned e0);
    idle();
    idle();
    $display("test %0d %s: %0d checks, %0d errors", num, name, checks - c0, errors - e0);
  endtask

  initial begin
    #(2 * TOTAL_CYCLES * PERIOD);
    $display("timeout: the tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    int unsigned c0;
    int unsigned e0;
    int unsigned ra;
    int unsigned wa;
    int unsigned row;
    int unsigned total;
    void'($urandom(32'hf07d));
    read = 1'b0;
    write = 1'b0;
    rd_adr = '0;
    wr_adr = '0;
    din = '0;
    wait (rst === 1'b0);

    c0 = checks;
    e0 = errors;
    for (int a = 0; a < NUMADR; a++) drive_cycle(1'b0, 0, 1'b1, a, WIDTH'($urandom));
    for (int a = 0; a < NUMADR; a++) drive_cycle(1'b1, a, 1'b0, 0, '0);
    end_test(1, "fill and read back", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_STEER; i++) begin
      ra  = $urandom_range(NUMADR - 1, 0);
      row = (row_of(ra, BITVBNK) + 1 + $urandom_range(DEF_NUMVROW - 2, 0)) % DEF_NUMVROW;
      wa  = make_adr(row, bank_of(ra, BITVBNK));
      drive_cycle(1'b1, ra, 1'b1, wa, WIDTH'($urandom));
      drive_cycle(1'b1, wa, 1'b0, 0, '0);
    end
    end_test(2, "bank conflict steering", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_SAME; i++) begin
      ra = $urandom_range(NUMADR - 1, 0);
      drive_cycle(1'b1, ra, 1'b1, ra, WIDTH'($urandom));
      drive_cycle(1'b1, ra, 1'b0, 0, '0);
    end
    end_test(3, "same address read and write", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_TIMING; i++) begin
      repeat ($urandom_range(3, 0)) idle();
      drive_cycle(1'b1, $urandom_range(NUMADR - 1, 0), 1'b0, 0, '0);
    end
    end_test(4, "response timing", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_RANDOM; i++) begin
      ra = $urandom_range(NUMADR - 1, 0);
      // half the writes share the read's logical bank to force conflicts
      if ($urandom_range(1, 0) == 1) begin
        wa = make_adr($urandom_range(DEF_NUMVROW - 1, 0), bank_of(ra, BITVBNK));
      end else begin
        wa = $urandom_range(NUMADR - 1, 0);
      end
      drive_cycle($urandom_range(3, 0) != 0, ra, $urandom_range(3, 0) != 0, wa,
                  WIDTH'($urandom));
    end
    end_test(5, "random traffic", c0, e0);

    total = errors + UUT.u_remap_table.u_chk.fail_cnt;
    $display("tests 5, checks %0d, errors %0d, assertion failures %0d", checks, errors,
             UUT.u_remap_table.u_chk.fail_cnt);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- remap_mem.f
common/mem_geom_pkg.sv
common/remap_pkg.sv
design/remap/remap_table.sv
design/sram_bank.sv
design/read_select.sv
design/remap_mem_top.sv
verif/clk_gen.sv
verif/remap_mem_chk.sv
verif/remap_mem_tb.sv

//--- Bender.yml
package:
  name: remap_mem

sources:
  - files:
      - common/mem_geom_pkg.sv
      - common/remap_pkg.sv
      - design/remap/remap_table.sv
      - design/sram_bank.sv
      - design/read_select.sv
      - design/remap_mem_top.sv
  - target: test
    files:
      - verif/clk_gen.sv
      - verif/remap_mem_chk.sv
      - verif/remap_mem_tb.sv
